/* verilog/ooo_pkg.sv */
// Shared constants and packed structs for the out-of-order retirement subsystem.
// Import into every block that carries dispatch, completion or commit traffic.

`default_nettype none

package ooo_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    localparam int unsigned xlen        = 32;
    localparam int unsigned rob_size    = 8;
    localparam int unsigned rob_idx_len = 3;
    localparam int unsigned arch_regs   = 32;
    localparam int unsigned reg_idx_len = 5;

    typedef logic [rob_idx_len-1:0] rob_tag_t;
    typedef logic [reg_idx_len-1:0] reg_idx_t;
    typedef logic [xlen-1:0]        word_t;

    // hard-wired zero register
    localparam reg_idx_t zero_reg = '0;

    ////////////////////////////////////////////////////////////
    // packets between the blocks
    ////////////////////////////////////////////////////////////

    // instruction entering the window this cycle
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t dest_reg;
        reg_idx_t src1_reg;
        reg_idx_t src2_reg;
    } dispatch_packet_t;

    // result from a functional unit, any order
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
        logic     mis_pred;
    } complete_packet_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t dest_reg;
        word_t    value;
        logic     ready;
        logic     mis_pred;
    } rob_entry_t;

    // producer slots asked for by operand selection
    typedef struct packed {
        rob_tag_t tag1;
        rob_tag_t tag2;
    } rob_lookup_t;

    typedef struct packed {
        logic  ready1;
        word_t value1;
        logic  ready2;
        word_t value2;
    } rob_read_t;

    // head of the buffer leaving in program order
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        reg_idx_t dest_reg;
        word_t    value;
        word_t    pc;
        logic     squash;
    } commit_packet_t;

    typedef struct packed {
        logic     busy;
        rob_tag_t tag;
    } map_entry_t;

    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        word_t    value;
    } operand_t;

    typedef struct packed {
        operand_t op1;
        operand_t op2;
    } operand_packet_t;

endpackage

`default_nettype wire

/* verilog/reorder_buffer.sv */
// Circular reorder buffer: takes dispatches at the tail, completions in any order,
// and retires the head in program order. A mispredicted head flushes everything.

`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic                    clock,
    input  logic                    reset,
    input  ooo_pkg::dispatch_packet_t dispatch,
    input  ooo_pkg::complete_packet_t complete,
    input  ooo_pkg::rob_lookup_t    lookup,
    output ooo_pkg::rob_read_t      read,
    output ooo_pkg::rob_tag_t       tail,
    output logic                    rob_full,
    output ooo_pkg::commit_packet_t commit
);

    import ooo_pkg::*;

    // one extra bit so full and empty differ when head equals tail
    typedef logic [rob_idx_len:0] count_t;

    rob_entry_t entries [rob_size];
    rob_tag_t   head;
    count_t     count;

    logic       rob_empty;
    logic       retire;
    logic       squash;

    // distance of a completing slot from the head, for the protocol check
    rob_tag_t   complete_offset;
    logic       complete_in_flight;

    ////////////////////////////////////////////////////////////
    // status and retirement
    ////////////////////////////////////////////////////////////

    assign rob_empty = (count == '0);
    assign rob_full  = (count == count_t'(rob_size));
    assign retire    = !rob_empty && entries[head].ready;
    assign squash    = retire && entries[head].mis_pred;

    assign commit.valid    = retire;
    assign commit.tag      = head;
    assign commit.dest_reg = entries[head].dest_reg;
    assign commit.value    = entries[head].value;
    assign commit.pc       = entries[head].pc;
    assign commit.squash   = squash;

    // operand read-back, no bypass of this cycle's completion
    assign read.ready1 = entries[lookup.tag1].ready;
    assign read.value1 = entries[lookup.tag1].value;
    assign read.ready2 = entries[lookup.tag2].ready;
    assign read.value2 = entries[lookup.tag2].value;

    assign complete_offset    = complete.tag - head;
    assign complete_in_flight = ({1'b0, complete_offset} < count);

    ////////////////////////////////////////////////////////////
    // state update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            // flush drops the dispatch and any completion of this cycle
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_size; i++) begin
                entries[i] <= '0;
            end
        end else begin
            if (dispatch.valid) begin
                entries[tail] <= '{
                    pc:       dispatch.pc,
                    dest_reg: dispatch.dest_reg,
                    value:    '0,
                    ready:    1'b0,
                    mis_pred: 1'b0
                };
                tail <= tail + rob_tag_t'(1);
            end

            if (complete.valid) begin
                entries[complete.tag].value    <= complete.value;
                entries[complete.tag].mis_pred <= complete.mis_pred;
                entries[complete.tag].ready    <= 1'b1;
            end

            if (retire) begin
                head <= head + rob_tag_t'(1);
            end

            case ({dispatch.valid, retire})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // protocol checks
    ////////////////////////////////////////////////////////////

    // caller must honour rob_full
    assert property (@(posedge clock) disable iff (reset)
        dispatch.valid |-> !rob_full)
        else $error("dispatch while reorder buffer full");

    // completion names an occupied slot still waiting for its result
    assert property (@(posedge clock) disable iff (reset)
        complete.valid |-> complete_in_flight && !entries[complete.tag].ready)
        else $error("completion to empty or ready slot %0d", complete.tag);

    assert property (@(posedge clock) disable iff (reset)
        count <= count_t'(rob_size))
        else $error("occupancy counter overflow");

endmodule

`default_nettype wire

/* verilog/rename_map.sv */
// Rename map: for each architectural register, the reorder buffer slot that will
// produce it. Set at dispatch, released at commit, wiped on squash.

`timescale 1ns/1ps
`default_nettype none

module rename_map (
    input  logic                      clock,
    input  logic                      reset,
    input  ooo_pkg::dispatch_packet_t dispatch,
    input  ooo_pkg::rob_tag_t         tail,
    input  ooo_pkg::commit_packet_t   commit,
    output ooo_pkg::map_entry_t       map [ooo_pkg::arch_regs]
);

    import ooo_pkg::*;

    logic rename_valid;
    logic release_valid;

    ////////////////////////////////////////////////////////////
    // update conditions
    ////////////////////////////////////////////////////////////

    // register 0 never gets a producer
    assign rename_valid = dispatch.valid && (dispatch.dest_reg != zero_reg);

    // only release when no younger instruction took the register over
    assign release_valid = commit.valid
                        && map[commit.dest_reg].busy
                        && (map[commit.dest_reg].tag == commit.tag);

    always_ff @(posedge clock) begin
        if (reset || commit.squash) begin
            for (int i = 0; i < arch_regs; i++) begin
                map[i] <= '0;
            end
        end else begin
            if (release_valid) begin
                map[commit.dest_reg].busy <= 1'b0;
            end
            // later write wins, so a rename of the same register beats the release
            if (rename_valid) begin
                map[dispatch.dest_reg] <= '{busy: 1'b1, tag: tail};
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clock) disable iff (reset)
        !map[zero_reg].busy)
        else $error("register 0 marked busy");

endmodule

`default_nettype wire

/* verilog/operand_resolve.sv */
// Architectural register file and source operand selection. Each source comes
// from the zero register, a ready buffer slot, a pending tag, or the register file.

`timescale 1ns/1ps
`default_nettype none

module operand_resolve (
    input  logic                      clock,
    input  logic                      reset,
    input  ooo_pkg::dispatch_packet_t dispatch,
    input  ooo_pkg::map_entry_t       map [ooo_pkg::arch_regs],
    input  ooo_pkg::rob_read_t        read,
    input  ooo_pkg::commit_packet_t   commit,
    output ooo_pkg::rob_lookup_t      lookup,
    output ooo_pkg::operand_packet_t  operands
);

    import ooo_pkg::*;

    word_t regfile [arch_regs];

    // pick one source operand; tag is the producer whenever the register is busy
    function automatic operand_t resolve(
        input reg_idx_t   src,
        input map_entry_t entry,
        input logic       slot_ready,
        input word_t      slot_value,
        input word_t      rf_value
    );
        operand_t op;
        op = '{ready: 1'b1, tag: '0, value: '0};
        if (src == zero_reg) begin
            op.value = '0;
        end else if (entry.busy && slot_ready) begin
            op.tag   = entry.tag;
            op.value = slot_value;
        end else if (entry.busy) begin
            op.ready = 1'b0;
            op.tag   = entry.tag;
        end else begin
            op.value = rf_value;
        end
        return op;
    endfunction

    ////////////////////////////////////////////////////////////
    // operand lookup
    ////////////////////////////////////////////////////////////

    assign lookup.tag1 = map[dispatch.src1_reg].tag;
    assign lookup.tag2 = map[dispatch.src2_reg].tag;

    assign operands.op1 = resolve(dispatch.src1_reg, map[dispatch.src1_reg],
                                  read.ready1, read.value1, regfile[dispatch.src1_reg]);
    assign operands.op2 = resolve(dispatch.src2_reg, map[dispatch.src2_reg],
                                  read.ready2, read.value2, regfile[dispatch.src2_reg]);

    ////////////////////////////////////////////////////////////
    // register file write at commit
    ////////////////////////////////////////////////////////////

    // a squashing commit still writes its own result
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < arch_regs; i++) begin
                regfile[i] <= '0;
            end
        end else if (commit.valid && (commit.dest_reg != zero_reg)) begin
            regfile[commit.dest_reg] <= commit.value;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        regfile[zero_reg] == '0)
        else $error("register 0 holds a non-zero value");

endmodule

`default_nettype wire

/* verilog/ooo_core.sv */
// Top level of the retirement subsystem: reorder buffer, rename map and operand
// selection wired together. The outside drives dispatch and complete strobes.

`timescale 1ns/1ps
`default_nettype none

module ooo_core (
    input  logic                      clock,
    input  logic                      reset,
    input  ooo_pkg::dispatch_packet_t dispatch,
    input  ooo_pkg::complete_packet_t complete,
    output logic                      rob_full,
    output ooo_pkg::rob_tag_t         dispatch_tag,
    output ooo_pkg::operand_packet_t  operands,
    output ooo_pkg::commit_packet_t   commit
);

    import ooo_pkg::*;

    rob_lookup_t lookup;
    rob_read_t   read_back;
    map_entry_t  map_table [arch_regs];

    // in-order window, answers operand lookups combinationally
    reorder_buffer i_reorder_buffer (
        .clock    (clock),
        .reset    (reset),
        .dispatch (dispatch),
        .complete (complete),
        .lookup   (lookup),
        .read     (read_back),
        .tail     (dispatch_tag),
        .rob_full (rob_full),
        .commit   (commit)
    );

    // producer slot per register, takes the tail as the new tag
    rename_map i_rename_map (
        .clock    (clock),
        .reset    (reset),
        .dispatch (dispatch),
        .tail     (dispatch_tag),
        .commit   (commit),
        .map      (map_table)
    );

    // register file and source selection
    operand_resolve i_operand_resolve (
        .clock    (clock),
        .reset    (reset),
        .dispatch (dispatch),
        .map      (map_table),
        .read     (read_back),
        .commit   (commit),
        .lookup   (lookup),
        .operands (operands)
    );

endmodule

`default_nettype wire

/* test/ooo_core_tb.sv */
// Testbench for the out-of-order retirement subsystem. Directed tests, then random traffic,
// all compared every cycle against a reference model of buffer, map and register file.

`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;

    import ooo_pkg::*;

    localparam int max_cycles = 2000;

    typedef struct packed {
        logic            rob_full;
        rob_tag_t        tag;
        operand_packet_t operands;
        commit_packet_t  commit;
    } expect_t;

    logic             clock;
    logic             reset;
    dispatch_packet_t dispatch;
    complete_packet_t complete;
    logic             rob_full;
    rob_tag_t         dispatch_tag;
    operand_packet_t  operands;
    commit_packet_t   commit;

    // reference model state
    logic     slot_used  [rob_size];
    logic     slot_ready [rob_size];
    logic     slot_mis   [rob_size];
    word_t    slot_value [rob_size];
    reg_idx_t slot_dest  [rob_size];
    word_t    slot_pc    [rob_size];
    rob_tag_t ref_head;
    rob_tag_t ref_tail;
    int       ref_count;
    logic     map_busy [arch_regs];
    rob_tag_t map_tag  [arch_regs];
    word_t    ref_regs [arch_regs];

    int             errors;
    int             checks;
    int             test_start_errors;
    int             cycles;
    logic [31:0]    rng_state;
    word_t          next_pc;
    commit_packet_t commit_log [$];

    ooo_core i_ooo_core (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .complete     (complete),
        .rob_full     (rob_full),
        .dispatch_tag (dispatch_tag),
        .operands     (operands),
        .commit       (commit)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: tests did not finish within %0d cycles", max_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic check(input string name, input logic [127:0] actual,
                         input logic [127:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    function automatic dispatch_packet_t make_dispatch(input logic valid, input reg_idx_t dest,
                                                       input reg_idx_t src1, input reg_idx_t src2);
        dispatch_packet_t d;
        d = '{valid: valid, pc: next_pc, dest_reg: dest, src1_reg: src1, src2_reg: src2};
        next_pc += 4;
        return d;
    endfunction

    function automatic complete_packet_t make_complete(input rob_tag_t tag, input word_t value,
                                                       input logic mis_pred);
        return '{valid: 1'b1, tag: tag, value: value, mis_pred: mis_pred};
    endfunction

    // inputs change on the falling edge only
    task automatic drive(input dispatch_packet_t d, input complete_packet_t c);
        @(negedge clock);
        dispatch <= d;
        complete <= c;
    endtask

    task automatic idle(input int n);
        repeat (n) drive('0, '0);
    endtask

    task automatic wait_commits(input int n);
        while (commit_log.size() < n) drive('0, '0);
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    task automatic clear_window();
        for (int i = 0; i < rob_size; i++) begin
            slot_used[i]  = 1'b0;
            slot_ready[i] = 1'b0;
            slot_mis[i]   = 1'b0;
        end
        for (int i = 0; i < arch_regs; i++) map_busy[i] = 1'b0;
        ref_head  = '0;
        ref_tail  = '0;
        ref_count = 0;
    endtask

    task automatic update_model();
        rob_tag_t h;
        logic     retire;
        h      = ref_head;
        retire = (ref_count != 0) && slot_ready[h];
        if (retire && slot_dest[h] != zero_reg) ref_regs[slot_dest[h]] = slot_value[h];
        if (retire && slot_mis[h]) begin
            // flush keeps the register file
            clear_window();
        end else begin
            if (retire && map_busy[slot_dest[h]] && map_tag[slot_dest[h]] == h)
                map_busy[slot_dest[h]] = 1'b0;
            if (dispatch.valid) begin
                if (dispatch.dest_reg != zero_reg) begin
                    map_busy[dispatch.dest_reg] = 1'b1;
                    map_tag[dispatch.dest_reg]  = ref_tail;
                end
                slot_used[ref_tail]  = 1'b1;
                slot_ready[ref_tail] = 1'b0;
                slot_mis[ref_tail]   = 1'b0;
                slot_dest[ref_tail]  = dispatch.dest_reg;
                slot_pc[ref_tail]    = dispatch.pc;
                ref_tail++;
                ref_count++;
            end
            if (complete.valid) begin
                slot_ready[complete.tag] = 1'b1;
                slot_value[complete.tag] = complete.value;
                slot_mis[complete.tag]   = complete.mis_pred;
            end
            if (retire) begin
                slot_used[h] = 1'b0;
                ref_head++;
                ref_count--;
            end
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            clear_window();
            for (int i = 0; i < arch_regs; i++) ref_regs[i] = '0;
        end else begin
            update_model();
        end
    end

    function automatic operand_t expected_operand(input reg_idx_t src);
        operand_t op;
        op = '{ready: 1'b1, tag: '0, value: '0};
        if (src != zero_reg && map_busy[src]) begin
            op.tag   = map_tag[src];
            op.ready = slot_ready[op.tag];
            op.value = slot_value[op.tag];
        end else if (src != zero_reg) begin
            op.value = ref_regs[src];
        end
        return op;
    endfunction

    function automatic expect_t expected_outputs(input dispatch_packet_t d);
        expect_t e;
        e = '0;
        e.rob_full        = (ref_count == rob_size);
        e.tag             = ref_tail;
        e.operands.op1    = expected_operand(d.src1_reg);
        e.operands.op2    = expected_operand(d.src2_reg);
        e.commit.valid    = (ref_count != 0) && slot_ready[ref_head];
        e.commit.tag      = ref_head;
        e.commit.dest_reg = slot_dest[ref_head];
        e.commit.value    = slot_value[ref_head];
        e.commit.pc       = slot_pc[ref_head];
        e.commit.squash   = e.commit.valid && slot_mis[ref_head];
        return e;
    endfunction

    task automatic compare_operand(input string name, input operand_t actual,
                                   input operand_t expected);
        check({name, ".ready"}, actual.ready, expected.ready);
        if (expected.ready) check({name, ".value"}, actual.value, expected.value);
        else check({name, ".tag"}, actual.tag, expected.tag);
    endtask

    // outputs are settled half a cycle after the inputs changed
    always @(negedge clock) begin : compare_outputs
        expect_t e;
        if (!reset) begin
            e = expected_outputs(dispatch);
            check("rob_full", rob_full, e.rob_full);
            check("dispatch_tag", dispatch_tag, e.tag);
            compare_operand("operands.op1", operands.op1, e.operands.op1);
            compare_operand("operands.op2", operands.op2, e.operands.op2);
            check("commit.valid", commit.valid, e.commit.valid);
            check("commit.squash", commit.squash, e.commit.squash);
            if (e.commit.valid) check("commit", commit, e.commit);
            if (commit.valid) commit_log.push_back(commit);
        end
    end

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    initial begin : run_tests
        dispatch_packet_t d;
        complete_packet_t c;
        logic [31:0]      r;
        rob_tag_t         cand;
        logic             found;
        reset = 1'b1;
        dispatch = '0;
        complete = '0;
        errors = 0;
        checks = 0;
        test_start_errors = 0;
        cycles = 0;
        rng_state = 32'd68381;
        next_pc = 32'h0000_1000;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset <= 1'b0;

        idle(2);
        #1;
        check("rob_full", rob_full, 1'b0);
        check("dispatch_tag", dispatch_tag, 0);
        check("commit.valid", commit.valid, 1'b0);
        check("commit.squash", commit.squash, 1'b0);
        check("operands", operands, {1'b1, 3'd0, 32'd0, 1'b1, 3'd0, 32'd0});
        end_test("reset");

        // four producers completed youngest first
        commit_log.delete();
        for (int i = 0; i < 4; i++) drive(make_dispatch(1'b1, reg_idx_t'(i + 1), 0, 0), '0);
        for (int i = 3; i >= 0; i--) drive('0, make_complete(rob_tag_t'(i), 32'hc0de_0000 + i, 0));
        wait_commits(4);
        for (int i = 0; i < 4; i++) begin
            check("commit.dest_reg", commit_log[i].dest_reg, i + 1);
            check("commit.value", commit_log[i].value, 32'hc0de_0000 + i);
        end
        end_test("in_order_commit");

        commit_log.delete();
        drive(make_dispatch(1'b1, 7, 0, 1), '0);
        drive(make_dispatch(1'b1, 5, 2, 0), '0);
        drive(make_dispatch(1'b1, 6, 5, 3), '0);
        #1;
        check("operands.op1.ready", operands.op1.ready, 1'b0);
        check("operands.op1.tag", operands.op1.tag, 5);
        check("operands.op2.value", operands.op2.value, 32'hc0de_0002);
        drive('0, make_complete(5, 32'h55, 0));
        drive(make_dispatch(1'b1, 8, 5, 6), '0);
        #1;
        check("operands.op1.value", operands.op1.value, 32'h55);
        check("operands.op2.tag", operands.op2.tag, 6);
        drive('0, make_complete(4, 32'h44, 0));
        drive('0, make_complete(6, 32'h66, 0));
        drive('0, make_complete(7, 32'h77, 0));
        wait_commits(4);
        drive(make_dispatch(1'b0, 0, 5, 8), '0);
        #1;
        check("operands", operands, {1'b1, 3'd0, 32'h55, 1'b1, 3'd0, 32'h77});
        end_test("operand_resolve");

        // fill all eight slots, tail wraps back to 0
        commit_log.delete();
        for (int i = 0; i < rob_size; i++) drive(make_dispatch(1'b1, reg_idx_t'(9 + i), 0, 0), '0);
        drive('0, '0);
        #1;
        check("rob_full", rob_full, 1'b1);
        check("dispatch_tag", dispatch_tag, 0);
        drive('0, make_complete(0, 32'h900, 0));
        wait_commits(1);
        drive('0, '0);
        #1;
        check("rob_full", rob_full, 1'b0);
        for (int i = 1; i < rob_size; i++) drive('0, make_complete(rob_tag_t'(i), 32'h900 + i, 0));
        wait_commits(rob_size);
        end_test("full_and_wrap");

        commit_log.delete();
        drive(make_dispatch(1'b1, 20, 0, 0), '0);
        drive(make_dispatch(1'b1, 21, 0, 0), '0);
        drive(make_dispatch(1'b1, 22, 0, 0), '0);
        drive('0, make_complete(1, 32'h2121, 0));
        drive('0, make_complete(0, 32'hbad0_2020, 1'b1));
        // lands on the squash edge and is dropped
        drive(make_dispatch(1'b1, 23, 0, 0), '0);
        idle(2);
        drive(make_dispatch(1'b0, 0, 20, 21), '0);
        #1;
        check("rob_full", rob_full, 1'b0);
        check("dispatch_tag", dispatch_tag, 0);
        check("operands", operands, {1'b1, 3'd0, 32'hbad0_2020, 1'b1, 3'd0, 32'd0});
        check("commit_log.size", commit_log.size(), 1);
        check("commit.squash", commit_log[0].squash, 1'b1);
        end_test("squash");

        for (int n = 0; n < 400; n++) begin
            @(negedge clock);
            r = next_random();
            d = make_dispatch(r[0] && (ref_count < rob_size), reg_idx_t'(r[5:1]),
                              reg_idx_t'(r[10:6]), reg_idx_t'(r[15:11]));
            c = '0;
            found = 1'b0;
            for (int k = 0; k < rob_size; k++) begin
                cand = rob_tag_t'(r[18:16] + k);
                if (!found && slot_used[cand] && !slot_ready[cand]) begin
                    found = 1'b1;
                    if (r[19]) c = make_complete(cand, next_random(), r[23:20] == 4'h0);
                end
            end
            dispatch <= d;
            complete <= c;
        end
        idle(2);
        end_test("random");

        $display("checks run: %0d, failed: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
verilog/ooo_pkg.sv
verilog/reorder_buffer.sv
verilog/rename_map.sv
verilog/operand_resolve.sv
verilog/ooo_core.sv
test/ooo_core_tb.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  # package first, then the blocks, then the top level
  - verilog/ooo_pkg.sv
  - verilog/reorder_buffer.sv
  - verilog/rename_map.sv
  - verilog/operand_resolve.sv
  - verilog/ooo_core.sv

  - target: test
    files:
      - test/ooo_core_tb.sv
